//--- common/gpu_defines.svh
// Size macros shared by the compute unit front end
// Include wherever a warp count, width or memory depth is needed

`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// Warps sharing the single fetch path
`define GPU_NUM_WARPS 8

// Program counter width in bits
`define GPU_PC_WIDTH 16

// Threads per warp, also the active mask width
`define GPU_WARP_WIDTH 4

// Encoded instruction width in bits
`define GPU_INST_WIDTH 32

// Instruction memory words, indexed by the low pc bits
`define GPU_IMEM_DEPTH 256

`endif

//--- common/gpu_types_pkg.sv
// Data path types of the instruction front end
// Holds the basic words and the payloads of both pipeline links

`default_nettype none

`include "gpu_defines.svh"

package gpu_types_pkg;

    // ##################################################
    // Basic words
    // ##################################################

    // Warp index
    typedef logic [$clog2(`GPU_NUM_WARPS)-1:0] wid_t;

    // Program counter in instruction words
    typedef logic [`GPU_PC_WIDTH-1:0] pc_t;

    // One bit per thread of a warp
    typedef logic [`GPU_WARP_WIDTH-1:0] act_mask_t;

    // Raw instruction word, not decoded here
    typedef logic [`GPU_INST_WIDTH-1:0] enc_inst_t;

    // ##################################################
    // Stage payloads
    // ##################################################

    // Fetch request from fetcher to cache
    typedef struct packed {
        pc_t       pc;
        act_mask_t act_mask;
        wid_t      warp_id;
    } fe_to_ic_t;

    // Decoder payload, the request plus the fetched word
    typedef struct packed {
        pc_t       pc;
        act_mask_t act_mask;
        wid_t      warp_id;
        enc_inst_t inst;
    } ic_to_dec_t;

endpackage

`default_nettype wire

//--- common/gpu_ctrl_pkg.sv
// Control types of the instruction front end
// Warp state encoding plus the launch and memory write commands

`default_nettype none

`include "gpu_defines.svh"

package gpu_ctrl_pkg;

    // Per-warp fetch state
    typedef enum logic [1:0] {
        WARP_IDLE  = 2'd0, // Not launched yet
        WARP_READY = 2'd1, // Allowed to fetch
        WARP_WAIT  = 2'd2  // One instruction in flight
    } warp_state_e;

    // Start of a warp
    typedef struct packed {
        gpu_types_pkg::wid_t      warp_id;
        gpu_types_pkg::pc_t       pc;
        gpu_types_pkg::act_mask_t act_mask;
    } launch_req_t;

    // Word address into instruction memory
    typedef logic [$clog2(`GPU_IMEM_DEPTH)-1:0] imem_addr_t;

    // Program load into instruction memory
    typedef struct packed {
        imem_addr_t               addr;
        gpu_types_pkg::enc_inst_t data;
    } imem_write_t;

endpackage

`default_nettype wire

//--- src/stream_register.sv
// One-entry valid/ready pipeline register for any payload type
// Cuts the combinational path between two stream stages

`timescale 1ns/100ps
`default_nettype none

module stream_register #(
    // Payload carried through the register
    parameter type T = logic
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    // Upstream side
    input  wire logic valid_i,
    output logic      ready_o,
    input  wire T     data_i,

    // Downstream side
    output logic      valid_o,
    input  wire logic ready_i,
    output T          data_o
);

    // Occupancy flag and stored item
    logic valid_q;
    T     data_q;

    // Free slot, or the slot drains this cycle
    assign ready_o = ~valid_q | ready_i;

    assign valid_o = valid_q;
    assign data_o  = data_q;

    // Occupancy follows the upstream valid whenever a load is allowed
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // Capture only on a real transfer
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- fetcher/warp_arbiter.sv
// Round-robin grant among warps that may fetch
// A shown grant stays fixed until the fetch path accepts it

`timescale 1ns/100ps
`default_nettype none

`include "gpu_defines.svh"

module warp_arbiter (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,

    input  wire logic [`GPU_NUM_WARPS-1:0] req_i,
    input  wire logic                 accept_i,

    output logic                      gnt_valid_o,
    output gpu_types_pkg::wid_t       gnt_id_o
);

    import gpu_types_pkg::*;

    // Warp with highest priority in the next search
    wid_t prio_q;

    // Held grant while the fetch path stalls
    logic lock_q;
    wid_t lock_id_q;

    // Search result
    logic found;
    wid_t found_id;
    wid_t search_idx;

    // ##################################################
    // First request at or after the pointer
    // ##################################################

    always_comb begin
        found      = 1'b0;
        found_id   = prio_q;
        search_idx = prio_q;
        for (int i = 0; i < `GPU_NUM_WARPS; i++) begin
            // Index wraps with the warp id width
            search_idx = prio_q + wid_t'(i);
            if (!found && req_i[search_idx]) begin
                found    = 1'b1;
                found_id = search_idx;
            end
        end
    end

    // Locked grant wins over a new search
    assign gnt_valid_o = lock_q | found;
    assign gnt_id_o    = lock_q ? lock_id_q : found_id;

    // ##################################################
    // Pointer and lock
    // ##################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q    <= '0;
            lock_q    <= 1'b0;
            lock_id_q <= '0;
        end else if (gnt_valid_o && accept_i) begin
            // Next search starts after the winner
            prio_q <= gnt_id_o + wid_t'(1);
            lock_q <= 1'b0;
        end else if (gnt_valid_o) begin
            lock_q    <= 1'b1;
            lock_id_q <= gnt_id_o;
        end
    end

endmodule

`default_nettype wire

//--- fetcher/fetcher.sv
// Warp table and fetch request issue for one compute unit
// Each warp keeps a state, pc and mask, and issues one fetch at a time

`timescale 1ns/100ps
`default_nettype none

`include "gpu_defines.svh"

module fetcher (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,

    // Warp launch
    input  wire logic                        launch_i,
    input  wire gpu_ctrl_pkg::launch_req_t   launch_req_i,

    // Instruction buffer space per warp
    input  wire logic [`GPU_NUM_WARPS-1:0]   ib_space_available_i,

    // Fetch request stream
    output logic                             fe_valid_o,
    input  wire logic                        fe_ready_i,
    output gpu_types_pkg::fe_to_ic_t         fe_req_o,

    // Decoder feedback
    input  wire logic                        dec_decoded_i,
    input  wire gpu_types_pkg::wid_t         dec_decoded_warp_id_i
);

    import gpu_types_pkg::*;
    import gpu_ctrl_pkg::*;

    // ##################################################
    // Warp table
    // ##################################################

    warp_state_e warp_state_q [`GPU_NUM_WARPS];
    pc_t         pc_q         [`GPU_NUM_WARPS];
    act_mask_t   act_mask_q   [`GPU_NUM_WARPS];

    // Arbiter side
    logic [`GPU_NUM_WARPS-1:0] fetch_req;
    logic                      gnt_valid;
    wid_t                      gnt_id;
    logic                      fetch_accept;

    // Ready warps with room in their buffer
    always_comb begin
        for (int w = 0; w < `GPU_NUM_WARPS; w++) begin
            fetch_req[w] = (warp_state_q[w] == WARP_READY) && ib_space_available_i[w];
        end
    end

    // ##################################################
    // Warp selection
    // ##################################################

    warp_arbiter i_warp_arbiter (
        .clk_i      ( clk_i        ),
        .rst_n_i    ( rst_n_i      ),
        .req_i      ( fetch_req    ),
        .accept_i   ( fetch_accept ),
        .gnt_valid_o( gnt_valid    ),
        .gnt_id_o   ( gnt_id       )
    );

    // Request built from the granted entry
    assign fe_valid_o        = gnt_valid;
    assign fe_req_o.pc       = pc_q[gnt_id];
    assign fe_req_o.act_mask = act_mask_q[gnt_id];
    assign fe_req_o.warp_id  = gnt_id;

    assign fetch_accept = fe_valid_o & fe_ready_i;

    // ##################################################
    // State update
    // ##################################################

    // Launch overwrites any state, then issue or decode feedback
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < `GPU_NUM_WARPS; w++) begin
                warp_state_q[w] <= WARP_IDLE;
            end
        end else begin
            for (int w = 0; w < `GPU_NUM_WARPS; w++) begin
                if (launch_i && (launch_req_i.warp_id == wid_t'(w))) begin
                    warp_state_q[w] <= WARP_READY;
                end else if (fetch_accept && (gnt_id == wid_t'(w))) begin
                    // Only one instruction in flight per warp
                    warp_state_q[w] <= WARP_WAIT;
                end else if (dec_decoded_i && (dec_decoded_warp_id_i == wid_t'(w))
                             && (warp_state_q[w] == WARP_WAIT)) begin
                    warp_state_q[w] <= WARP_READY;
                end
            end
        end
    end

    // Pc and mask, only meaningful once launched
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `GPU_NUM_WARPS; w++) begin
            if (launch_i && (launch_req_i.warp_id == wid_t'(w))) begin
                pc_q[w]       <= launch_req_i.pc;
                act_mask_q[w] <= launch_req_i.act_mask;
            end else if (fetch_accept && (gnt_id == wid_t'(w))) begin
                // No branches, step to the next word
                pc_q[w] <= pc_q[w] + pc_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- icache/instruction_cache.sv
// Instruction memory of the compute unit, always fully loaded
// Written through a strobe port, read combinationally per fetch request

`timescale 1ns/100ps
`default_nettype none

`include "gpu_defines.svh"

module instruction_cache (
    input  wire logic                      clk_i,

    // Program load
    input  wire logic                      imem_we_i,
    input  wire gpu_ctrl_pkg::imem_write_t imem_write_i,

    // Fetch side
    input  wire logic                      fe_valid_i,
    output logic                           ic_ready_o,
    input  wire gpu_types_pkg::fe_to_ic_t  fe_req_i,

    // Decoder side
    output logic                           ic_valid_o,
    input  wire logic                      dec_ready_i,
    output gpu_types_pkg::ic_to_dec_t      ic_data_o
);

    import gpu_types_pkg::*;
    import gpu_ctrl_pkg::*;

    // ##################################################
    // Memory array
    // ##################################################

    enc_inst_t imem_q [`GPU_IMEM_DEPTH];

    // Read index from the low pc bits
    imem_addr_t rd_addr;

    assign rd_addr = fe_req_i.pc[$bits(imem_addr_t)-1:0];

    // Synchronous write port
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem_q[imem_write_i.addr] <= imem_write_i.data;
        end
    end

    // ##################################################
    // Read path
    // ##################################################

    // No miss, so the handshake passes straight through
    assign ic_valid_o = fe_valid_i;
    assign ic_ready_o = dec_ready_i;

    // Request fields travel with the fetched word
    assign ic_data_o.pc       = fe_req_i.pc;
    assign ic_data_o.act_mask = fe_req_i.act_mask;
    assign ic_data_o.warp_id  = fe_req_i.warp_id;
    assign ic_data_o.inst     = imem_q[rd_addr];

endmodule

`default_nettype wire

//--- src/compute_unit.sv
// Top of the compute unit instruction front end
// Fetcher, two stream registers and the cache, ending at the decoder port

`timescale 1ns/100ps
`default_nettype none

`include "gpu_defines.svh"

module compute_unit (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,

    // Warp launch
    input  wire logic                      launch_i,
    input  wire gpu_ctrl_pkg::launch_req_t launch_req_i,

    // Program load
    input  wire logic                      imem_we_i,
    input  wire gpu_ctrl_pkg::imem_write_t imem_write_i,

    // Instruction buffer space per warp
    input  wire logic [`GPU_NUM_WARPS-1:0] ib_space_available_i,

    // Decoder port
    input  wire logic                      dec_ready_i,
    output logic                           dec_valid_o,
    output gpu_types_pkg::ic_to_dec_t      dec_data_o,

    // Decoder feedback
    input  wire logic                      dec_decoded_i,
    input  wire gpu_types_pkg::wid_t       dec_decoded_warp_id_i
);

    import gpu_types_pkg::*;

    // Fetcher to first register
    logic       fe_valid;
    logic       fe_ready;
    fe_to_ic_t  fe_req;

    // First register to cache
    logic       fe_q_valid;
    logic       fe_q_ready;
    fe_to_ic_t  fe_q_req;

    // Cache to second register
    logic       ic_valid;
    logic       ic_ready;
    ic_to_dec_t ic_data;

    // ##################################################
    // Fetch
    // ##################################################

    fetcher i_fetcher (
        .clk_i                ( clk_i                 ),
        .rst_n_i              ( rst_n_i               ),
        .launch_i             ( launch_i              ),
        .launch_req_i         ( launch_req_i          ),
        .ib_space_available_i ( ib_space_available_i  ),
        .fe_valid_o           ( fe_valid              ),
        .fe_ready_i           ( fe_ready              ),
        .fe_req_o             ( fe_req                ),
        .dec_decoded_i        ( dec_decoded_i         ),
        .dec_decoded_warp_id_i( dec_decoded_warp_id_i )
    );

    // First stage register
    stream_register #(
        .T( fe_to_ic_t )
    ) fe_to_ic_reg (
        .clk_i  ( clk_i      ),
        .rst_n_i( rst_n_i    ),
        .valid_i( fe_valid   ),
        .ready_o( fe_ready   ),
        .data_i ( fe_req     ),
        .valid_o( fe_q_valid ),
        .ready_i( fe_q_ready ),
        .data_o ( fe_q_req   )
    );

    // ##################################################
    // Lookup and decoder link
    // ##################################################

    instruction_cache i_instruction_cache (
        .clk_i       ( clk_i        ),
        .imem_we_i   ( imem_we_i    ),
        .imem_write_i( imem_write_i ),
        .fe_valid_i  ( fe_q_valid   ),
        .ic_ready_o  ( fe_q_ready   ),
        .fe_req_i    ( fe_q_req     ),
        .ic_valid_o  ( ic_valid     ),
        .dec_ready_i ( ic_ready     ),
        .ic_data_o   ( ic_data      )
    );

    // Second stage register, drives the decoder port
    stream_register #(
        .T( ic_to_dec_t )
    ) ic_to_dec_reg (
        .clk_i  ( clk_i       ),
        .rst_n_i( rst_n_i     ),
        .valid_i( ic_valid    ),
        .ready_o( ic_ready    ),
        .data_i ( ic_data     ),
        .valid_o( dec_valid_o ),
        .ready_i( dec_ready_i ),
        .data_o ( dec_data_o  )
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Clock and reset source for the compute unit testbench
// 100 ns period, reset held low for the first cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the capture edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/tb_compute_unit.sv
// Directed testbench for the compute unit instruction front end
// Loads random program words, launches warps and checks every decoder payload

`timescale 1ns/100ps
`default_nettype none

`include "gpu_defines.svh"

module tb_compute_unit;

    import gpu_types_pkg::*;
    import gpu_ctrl_pkg::*;

    // Cycle budget per test, summed for the watchdog
    localparam int LOAD_CYCLES = `GPU_IMEM_DEPTH + 20;
    localparam int TEST_CYCLES = 20 + 120 + 120 + 150 + 100 + 460;
    localparam int WATCHDOG_CYCLES = 10 + LOAD_CYCLES + TEST_CYCLES + 200;

    logic clk;
    logic rst_n;

    // DUT inputs and outputs
    logic                      launch_i;
    launch_req_t               launch_req_i;
    logic                      imem_we_i;
    imem_write_t               imem_write_i;
    logic [`GPU_NUM_WARPS-1:0] ib_space_available_i;
    logic                      dec_ready_i;
    logic                      dec_valid_o;
    ic_to_dec_t                dec_data_o;
    logic                      dec_decoded_i;
    wid_t                      dec_decoded_warp_id_i;

    // Reference model state
    enc_inst_t mem_model   [`GPU_IMEM_DEPTH];
    logic      launched    [`GPU_NUM_WARPS];
    pc_t       launch_pc   [`GPU_NUM_WARPS];
    act_mask_t launch_mask [`GPU_NUM_WARPS];
    int        issued      [`GPU_NUM_WARPS];
    wid_t      seen_q[$];

    // Responder modes and bookkeeping
    logic   auto_decode;
    logic   random_ready;
    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;

    tb_clock_gen #(
        .PERIOD_NS   ( 100 ),
        .RESET_CYCLES( 10  )
    ) i_clock_gen (
        .clk_o  ( clk   ),
        .rst_n_o( rst_n )
    );

    compute_unit dut_i (
        .clk_i                ( clk                   ),
        .rst_n_i              ( rst_n                 ),
        .launch_i             ( launch_i              ),
        .launch_req_i         ( launch_req_i          ),
        .imem_we_i            ( imem_we_i             ),
        .imem_write_i         ( imem_write_i          ),
        .ib_space_available_i ( ib_space_available_i  ),
        .dec_ready_i          ( dec_ready_i           ),
        .dec_valid_o          ( dec_valid_o           ),
        .dec_data_o           ( dec_data_o            ),
        .dec_decoded_i        ( dec_decoded_i         ),
        .dec_decoded_warp_id_i( dec_decoded_warp_id_i )
    );

    // ##################################################
    // Compare tasks
    // ##################################################

    task automatic compare_payload(input ic_to_dec_t got, input ic_to_dec_t exp, input string name);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_warp_id(input wid_t got, input wid_t exp, input string name);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_valid(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ##################################################
    // Model and cycle helpers
    // ##################################################

    // Expected pc is launch pc plus prior issues of that warp
    task automatic check_output(input ic_to_dec_t got);
        ic_to_dec_t exp;
        wid_t       w;
        w = got.warp_id;
        if (!launched[w]) begin
            $display("output from warp %0d, which was never launched", w);
            errors++;
        end else begin
            exp.pc       = launch_pc[w] + pc_t'(issued[w]);
            exp.act_mask = launch_mask[w];
            exp.warp_id  = w;
            exp.inst     = mem_model[exp.pc % `GPU_IMEM_DEPTH];
            compare_payload(got, exp, "dec_data_o");
            issued[w]++;
        end
        seen_q.push_back(w);
    endtask

    // Advance to the next falling edge and pick ready first
    // Then log the item that leaves on the coming rising edge
    task automatic tick();
        logic [31:0] rnd;
        @(negedge clk);
        dec_decoded_i = 1'b0;
        if (random_ready) begin
            rnd         = $random(seed);
            dec_ready_i = rnd[0];
        end
        if (dec_valid_o && dec_ready_i) begin
            check_output(dec_data_o);
            if (auto_decode) begin
                dec_decoded_i         = 1'b1;
                dec_decoded_warp_id_i = dec_data_o.warp_id;
            end
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < `GPU_IMEM_DEPTH; a++) begin
            imem_we_i         = 1'b1;
            imem_write_i.addr = imem_addr_t'(a);
            imem_write_i.data = $random(seed);
            mem_model[a]      = imem_write_i.data;
            tick();
        end
        imem_we_i = 1'b0;
    endtask

    task automatic launch_warp(input wid_t w, input pc_t pc, input act_mask_t mask);
        launch_i              = 1'b1;
        launch_req_i.warp_id  = w;
        launch_req_i.pc       = pc;
        launch_req_i.act_mask = mask;
        launched[w]           = 1'b1;
        launch_pc[w]          = pc;
        launch_mask[w]        = mask;
        issued[w]             = 0;
        tick();
        launch_i = 1'b0;
    endtask

    task automatic wait_for_outputs(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (seen_q.size() < n && cycles < limit) begin
            tick();
            cycles++;
        end
        if (seen_q.size() < n) begin
            $display("only %0d of %0d outputs arrived in %0d cycles", seen_q.size(), n, limit);
            errors++;
        end
    endtask

    // Stop decoding so every active warp parks in WAIT with nothing in flight
    task automatic drain_pipeline();
        int quiet;
        int cycles;
        auto_decode  = 1'b0;
        random_ready = 1'b0;
        dec_ready_i  = 1'b1;
        quiet        = 0;
        cycles       = 0;
        while (quiet < 10 && cycles < 50) begin
            tick();
            quiet = dec_valid_o ? 0 : quiet + 1;
            cycles++;
        end
        if (quiet < 10) begin
            $display("decoder port did not go quiet after the test");
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    // ##################################################
    // Tests
    // ##################################################

    task automatic test_idle_after_reset();
        int err_before;
        err_before = errors;
        repeat (20) begin
            tick();
            compare_valid(dec_valid_o, 1'b0, "dec_valid_o");
        end
        end_test("idle after reset", err_before);
    endtask

    task automatic test_sequential_fetch();
        int err_before;
        err_before = errors;
        seen_q.delete();
        auto_decode = 1'b1;
        launch_warp(3'd2, 16'd10, 4'b1011);
        wait_for_outputs(5, 60);
        foreach (seen_q[i]) begin
            compare_warp_id(seen_q[i], 3'd2, "dec_data_o.warp_id");
        end
        drain_pipeline();
        end_test("sequential fetch", err_before);
    endtask

    task automatic test_one_in_flight();
        int err_before;
        err_before = errors;
        auto_decode = 1'b0;
        launch_warp(3'd4, 16'd100, 4'b1111);
        repeat (30) tick();
        if (issued[4] != 1) begin
            $display("warp 4 gave %0d outputs with no decoded strobe, expected 1", issued[4]);
            errors++;
        end
        dec_decoded_i         = 1'b1;
        dec_decoded_warp_id_i = 3'd4;
        tick();
        repeat (29) tick();
        if (issued[4] != 2) begin
            $display("warp 4 gave %0d outputs after one decoded strobe, expected 2", issued[4]);
            errors++;
        end
        drain_pipeline();
        end_test("one instruction in flight", err_before);
    endtask

    task automatic test_round_robin();
        int   err_before;
        int   hits;
        wid_t rr_ids [3];
        err_before = errors;
        rr_ids     = '{3'd1, 3'd3, 3'd6};
        // Hold the three warps back so they become eligible together
        foreach (rr_ids[k]) begin
            ib_space_available_i[rr_ids[k]] = 1'b0;
        end
        launch_warp(3'd1, 16'd30, 4'b0001);
        launch_warp(3'd3, 16'd50, 4'b0011);
        launch_warp(3'd6, 16'd70, 4'b0111);
        seen_q.delete();
        auto_decode          = 1'b1;
        ib_space_available_i = '1;
        wait_for_outputs(9, 80);
        if (seen_q.size() >= 9) begin
            for (int g = 0; g < 3; g++) begin
                foreach (rr_ids[k]) begin
                    hits = 0;
                    for (int j = 0; j < 3; j++) begin
                        if (seen_q[3 * g + j] == rr_ids[k]) begin
                            hits++;
                        end
                    end
                    if (hits != 1) begin
                        $display("group %0d holds warp %0d %0d times", g, rr_ids[k], hits);
                        errors++;
                    end
                end
            end
        end
        drain_pipeline();
        end_test("round robin", err_before);
    endtask

    task automatic test_buffer_gating();
        int err_before;
        err_before = errors;
        ib_space_available_i[5] = 1'b0;
        auto_decode = 1'b1;
        launch_warp(3'd5, 16'd200, 4'b0110);
        seen_q.delete();
        // Every other warp is parked, so the port must stay idle
        repeat (20) begin
            tick();
            compare_valid(dec_valid_o, 1'b0, "dec_valid_o");
        end
        ib_space_available_i[5] = 1'b1;
        wait_for_outputs(1, 20);
        if (seen_q.size() > 0) begin
            compare_warp_id(seen_q[0], 3'd5, "dec_data_o.warp_id");
        end
        drain_pipeline();
        end_test("buffer space gating", err_before);
    endtask

    task automatic test_back_pressure();
        int   err_before;
        wid_t bp_ids [4];
        err_before = errors;
        bp_ids     = '{3'd0, 3'd2, 3'd5, 3'd7};
        // Early warps issue while the later ones launch, so decode from the start
        seen_q.delete();
        auto_decode  = 1'b1;
        random_ready = 1'b1;
        launch_warp(3'd0, 16'd250, 4'b1000);
        launch_warp(3'd2, 16'd120, 4'b1100);
        launch_warp(3'd5, 16'd160, 4'b1110);
        launch_warp(3'd7, 16'd220, 4'b0101);
        wait_for_outputs(24, 400);
        drain_pipeline();
        // Pc order and words were checked on every output
        foreach (bp_ids[k]) begin
            if (issued[bp_ids[k]] == 0) begin
                $display("warp %0d gave no output under back-pressure", bp_ids[k]);
                errors++;
            end
        end
        end_test("back-pressure", err_before);
    endtask

    // ##################################################
    // Sequence and watchdog
    // ##################################################

    initial begin
        seed                  = 32'h5be5_7367;
        errors                = 0;
        tests_run             = 0;
        tests_failed          = 0;
        auto_decode           = 1'b0;
        random_ready          = 1'b0;
        launch_i              = 1'b0;
        launch_req_i          = '0;
        imem_we_i             = 1'b0;
        imem_write_i          = '0;
        ib_space_available_i  = '1;
        dec_ready_i           = 1'b1;
        dec_decoded_i         = 1'b0;
        dec_decoded_warp_id_i = '0;
        for (int w = 0; w < `GPU_NUM_WARPS; w++) begin
            launched[w] = 1'b0;
            issued[w]   = 0;
        end
        @(posedge rst_n);
        tick();
        load_program();
        test_idle_after_reset();
        test_sequential_fetch();
        test_one_in_flight();
        test_round_robin();
        test_buffer_gating();
        test_back_pressure();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/gpu_types_pkg.sv
common/gpu_ctrl_pkg.sv
src/stream_register.sv
fetcher/warp_arbiter.sv
fetcher/fetcher.sv
icache/instruction_cache.sv
src/compute_unit.sv
dv/tb_clock_gen.sv
dv/tb_compute_unit.sv
